//--- hazardPkg.sv
package hazardPkg;

    parameter int dataWidth = 16;       // Fixed by the instruction set

    typedef logic [2:0] regIdxT;
    typedef logic [dataWidth-1:0] dataT;

    // Opcodes in instruction bits 15..11 that the hazard unit cares about
    typedef enum logic [4:0] {
        opNop = 5'b00001,
        opJ   = 5'b00100,
        opJal = 5'b00101,
        opJr  = 5'b00111
    } opcodeT;

    typedef struct packed {
        logic   valid;                  // Entry writes a register
        regIdxT rd;
    } regEntryT;

    typedef struct packed {
        logic valid;                    // Entry accesses memory
        dataT addr;
    } memEntryT;

    localparam regIdxT linkReg = 3'd7;  // Written by jump-and-link

    typedef struct packed {
        regIdxT rs;
        regIdxT rt;
        logic   isJump;                 // Plain jump, needs one bubble
        logic   isLink;
        logic   usesSrc;                // Low for NOP
    } decodeT;

endpackage

//--- trackIf.sv
interface trackIf #(
    parameter type EntryT = logic
);

    EntryT push;                        // Entry entering ID this cycle
    logic  flush;                       // Taken branch kills ID slot
    EntryT idE;
    EntryT exE;
    EntryT memE;
    EntryT wbE;

    modport pipe (
        input  push, flush,
        output idE, exE, memE, wbE
    );

    modport user (
        output push, flush,
        input  idE, exE, memE, wbE
    );

endinterface

//--- instrDecode.sv
module instrDecode (
    input  hazardPkg::dataT   instr,
    output hazardPkg::decodeT dec
);
    import hazardPkg::*;

    opcodeT op;

    assign op = opcodeT'(instr[15:11]);

    always_comb begin
        dec.isJump  = 1'b0;
        dec.isLink  = 1'b0;
        dec.usesSrc = 1'b1;
        dec.rs      = instr[10:8];
        dec.rt      = instr[7:5];

        case (op)
            opJ: begin
                dec.isJump = 1'b1;      // Bubble after a plain jump
            end
            opJal: begin
                dec.isLink = 1'b1;      // Result goes to r7
            end
            opNop: begin
                // No sources so both fields park on the same index
                dec.usesSrc = 1'b0;
                dec.rs      = '0;
                dec.rt      = '0;
            end
            default: begin
                // Branches and everything else read rs/rt as usual
            end
        endcase
    end

endmodule

//--- trackPipe.sv
module trackPipe #(
    parameter type EntryT = logic
) (
    input  logic clk,
    input  logic rstN,
    trackIf.pipe trk
);

    localparam EntryT emptyE = EntryT'(0);  // All zero means invalid

    // ID, EX, MEM, WB shift together every clock
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            trk.idE  <= emptyE;
            trk.exE  <= emptyE;
            trk.memE <= emptyE;
            trk.wbE  <= emptyE;
        end else begin
            trk.idE  <= trk.push;
            trk.exE  <= trk.flush ? emptyE : trk.idE;  // Branch kills the ID slot
            trk.memE <= trk.exE;
            trk.wbE  <= trk.memE;
        end
    end

    // Push comes from combinational logic on the top-level inputs
    idKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(trk.idE)
    ) else $error("trackPipe: ID stage entry is unknown");

endmodule

//--- memHazard.sv
module memHazard (
    input  logic            clk,
    input  logic            rstN,
    input  hazardPkg::dataT baseData,
    input  hazardPkg::dataT imm,
    input  logic            memEnable,
    input  logic            instrValid,
    input  logic            stall,
    input  logic            branchTaken,
    trackIf.user            trk,
    output logic            memHaz
);
    import hazardPkg::*;

    dataT     effAddr;
    memEntryT entry;
    logic     idHit;
    logic     laterHit;

    assign effAddr = baseData + imm;

    // Bubble when stalled or nothing issued
    always_comb begin
        entry.valid = instrValid & ~stall & memEnable;
        entry.addr  = effAddr;
    end

    assign trk.push  = entry;
    assign trk.flush = branchTaken;

    assign idHit = trk.idE.valid & (trk.idE.addr == effAddr) & ~branchTaken;

    assign laterHit = (trk.exE.valid & (trk.exE.addr == effAddr))
                    | (trk.memE.valid & (trk.memE.addr == effAddr))
                    | (trk.wbE.valid & (trk.wbE.addr == effAddr));

    // Does not use stall so the loop through hazardCtrl stays open
    assign memHaz = instrValid & memEnable & (idHit | laterHit);

    // The access in ID must be gone from EX after a taken branch
    flushKills: assert property (
        @(posedge clk) disable iff (!rstN)
        trk.flush |=> !trk.exE.valid
    ) else $error("memHazard: access killed by a taken branch reached EX");

endmodule

//--- hazardCtrl.sv
module hazardCtrl (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  hazardPkg::decodeT dec,
    input  hazardPkg::regIdxT rd,
    input  logic              regWrite,
    input  logic              branchTaken,
    input  logic              memHaz,
    trackIf.user              trk,
    output logic              stall,
    output logic [3:0]        forwards
);
    import hazardPkg::*;

    regEntryT entry;
    logic     srcValid;
    logic     regHaz;
    logic     jmpBubble;
    logic     idRs;
    logic     idRt;
    logic     exRs;
    logic     exRt;
    logic     olderRs;
    logic     olderRt;

    function automatic logic stageHit(regEntryT e, regIdxT r);
        return e.valid && (e.rd == r);
    endfunction

    assign srcValid = instrValid & dec.usesSrc;

    // ID slot does not count while a branch kills it
    assign idRs = stageHit(trk.idE, dec.rs) & ~branchTaken;
    assign idRt = stageHit(trk.idE, dec.rt) & ~branchTaken;
    assign exRs = stageHit(trk.exE, dec.rs);
    assign exRt = stageHit(trk.exE, dec.rt);

    assign olderRs = stageHit(trk.memE, dec.rs) | stageHit(trk.wbE, dec.rs);
    assign olderRt = stageHit(trk.memE, dec.rt) | stageHit(trk.wbE, dec.rt);

    assign regHaz = srcValid & (idRs | idRt | exRs | exRt | olderRs | olderRt);

    assign stall = regHaz | memHaz | jmpBubble;

    assign forwards[3] = srcValid & idRs;                 // EX to EX, rs
    assign forwards[2] = srcValid & exRs & ~branchTaken;  // MEM to EX, rs
    assign forwards[1] = srcValid & idRt;                 // EX to EX, rt
    assign forwards[0] = srcValid & exRt & ~branchTaken;  // MEM to EX, rt

    always_comb begin
        entry.valid = instrValid & ~stall & regWrite;
        entry.rd    = dec.isLink ? linkReg : rd;          // JAL always lands in r7
    end

    assign trk.push  = entry;
    assign trk.flush = branchTaken;

    // One-cycle bubble after an unstalled plain jump
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            jmpBubble <= 1'b0;
        end else begin
            jmpBubble <= instrValid & dec.isJump & ~stall;
        end
    end

    // A jump seen during the bubble is itself stalled
    bubbleOnce: assert property (
        @(posedge clk) disable iff (!rstN)
        jmpBubble |=> !jmpBubble
    ) else $error("hazardCtrl: jump bubble held for two cycles");

endmodule

//--- hazardUnit.sv
module hazardUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  hazardPkg::dataT    instr,
    input  hazardPkg::regIdxT  rd,
    input  logic               regWrite,
    input  logic               memEnable,
    input  hazardPkg::dataT    baseData,
    input  hazardPkg::dataT    imm,
    input  logic               branchTaken,
    output logic               stall,
    output logic [3:0]         forwards
);
    import hazardPkg::*;

    decodeT dec;
    logic   memHaz;

    trackIf #(.EntryT(regEntryT)) regTrk ();
    trackIf #(.EntryT(memEntryT)) memTrk ();

    instrDecode uDecode (
        .instr (instr),
        .dec   (dec)
    );

    hazardCtrl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .dec         (dec),
        .rd          (rd),
        .regWrite    (regWrite),
        .branchTaken (branchTaken),
        .memHaz      (memHaz),
        .trk         (regTrk.user),
        .stall       (stall),
        .forwards    (forwards)
    );

    memHazard uMem (
        .clk         (clk),
        .rstN        (rstN),
        .baseData    (baseData),
        .imm         (imm),
        .memEnable   (memEnable),
        .instrValid  (instrValid),
        .stall       (stall),
        .branchTaken (branchTaken),
        .trk         (memTrk.user),
        .memHaz      (memHaz)
    );

    trackPipe #(.EntryT(regEntryT)) uRegPipe (
        .clk  (clk),
        .rstN (rstN),
        .trk  (regTrk.pipe)
    );

    trackPipe #(.EntryT(memEntryT)) uMemPipe (
        .clk  (clk),
        .rstN (rstN),
        .trk  (memTrk.pipe)
    );

endmodule

//--- tbHazardUnit.sv
module tbHazardUnit;
    timeunit 1ns;
    timeprecision 100ps;

    import hazardPkg::*;

    localparam int    maxLines  = 200;
    localparam int    riseLimit = 8;      // Polls before giving up on the clock
    localparam string casesPath = "hazardCases.txt";

    typedef struct {
        int         lineNo;               // Position in the case file
        logic       instrValid;
        dataT       instr;
        regIdxT     rd;
        logic       regWrite;
        logic       memEnable;
        dataT       baseData;
        dataT       imm;
        logic       branchTaken;
        logic       expStall;
        logic [3:0] expForwards;
    } caseT;

    logic       clk = 1'b0;
    logic       rstN;
    logic       instrValid;
    dataT       instr;
    regIdxT     rd;
    logic       regWrite;
    logic       memEnable;
    dataT       baseData;
    dataT       imm;
    logic       branchTaken;
    logic       stall;
    logic [3:0] forwards;

    caseT cases[$];

    hazardUnit DUT (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rd          (rd),
        .regWrite    (regWrite),
        .memEnable   (memEnable),
        .baseData    (baseData),
        .imm         (imm),
        .branchTaken (branchTaken),
        .stall       (stall),
        .forwards    (forwards)
    );

    always #2 clk = ~clk;                 // 4 ns period

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    // Polls land half a ns after each edge when called between edges
    task automatic waitRise();
        int polls;
        bit sawLow;
        polls  = 0;
        sawLow = 1'b0;
        while (!(sawLow && clk === 1'b1)) begin
            if (clk === 1'b0) begin
                sawLow = 1'b1;
            end
            if (polls == riseLimit) begin
                stopOnFailure("The clock did not rise within the expected time");
            end
            #1;
            polls++;
        end
    endtask

    task automatic readCases();
        int    fd;
        int    lineCount;
        int    got;
        int    vIn, instrIn, rdIn, rwIn, meIn, baseIn, immIn, brIn, stallIn, fwdIn;
        string line;
        caseT  c;
        fd = $fopen(casesPath, "r");
        if (fd == 0) begin
            stopOnFailure("Could not open the case file hazardCases.txt");
        end
        lineCount = 0;
        while ($fgets(line, fd) != 0) begin
            lineCount++;
            if (lineCount > maxLines) begin
                stopOnFailure("The case file runs past the line limit");
            end
            got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", vIn, instrIn, rdIn,
                          rwIn, meIn, baseIn, immIn, brIn, stallIn, fwdIn);
            if (got == 10) begin
                c.lineNo      = lineCount;
                c.instrValid  = vIn[0];
                c.instr       = instrIn[15:0];
                c.rd          = rdIn[2:0];
                c.regWrite    = rwIn[0];
                c.memEnable   = meIn[0];
                c.baseData    = baseIn[15:0];
                c.imm         = immIn[15:0];
                c.branchTaken = brIn[0];
                c.expStall    = stallIn[0];
                c.expForwards = fwdIn[3:0];
                cases.push_back(c);
            end else if (got > 0) begin
                stopOnFailure($sformatf("Line %0d of the case file is malformed", lineCount));
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            stopOnFailure("The case file holds no cases");
        end
    endtask

    task automatic applyCase(input caseT c);
        instrValid  = c.instrValid;
        instr       = c.instr;
        rd          = c.rd;
        regWrite    = c.regWrite;
        memEnable   = c.memEnable;
        baseData    = c.baseData;
        imm         = c.imm;
        branchTaken = c.branchTaken;
    endtask

    task automatic checkOutputs(input caseT c);
        assert (stall === c.expStall) else begin
            stopOnFailure($sformatf("error at %0.1f ns: stall is %b, expected %b (line %0d)",
                                    $realtime, stall, c.expStall, c.lineNo));
        end
        assert (forwards === c.expForwards) else begin
            stopOnFailure($sformatf("error at %0.1f ns: forwards is %b, expected %b (line %0d)",
                                    $realtime, forwards, c.expForwards, c.lineNo));
        end
    endtask

    initial begin
        int idx;
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        rd          = '0;
        regWrite    = 1'b0;
        memEnable   = 1'b0;
        baseData    = '0;
        imm         = '0;
        branchTaken = 1'b0;
        readCases();

        #0.5;
        repeat (10) waitRise();           // Reset over ten rising edges
        rstN = 1'b1;

        for (idx = 0; idx < cases.size(); idx++) begin
            waitRise();
            applyCase(cases[idx]);
            #2.5;                         // 1 ns before the next edge
            checkOutputs(cases[idx]);
            #0.5;
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- hazardUnit.f
hazardPkg.sv
trackIf.sv
instrDecode.sv
trackPipe.sv
memHazard.sv
hazardCtrl.sv
hazardUnit.sv
tbHazardUnit.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the testbench reports a clean run
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbHazardUnit -f hazardUnit.f -o simHazardUnit \
    && ./obj_dir/simHazardUnit | tee /dev/stderr | grep -x "No errors" > /dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

//--- hazardCases.txt
// Columns valid instr rd regWrite memEnable baseData imm branchTaken then expected stall forwards
// Hex fields, one line per clock cycle
1 0140 3 1 0 0000 0000 0 0 0   // Producer of r3
1 0300 5 1 0 0000 0000 0 1 8   // Reader of r3 while producer is in ID
1 0300 5 1 0 0000 0000 0 1 4   // Producer now in EX
1 0300 5 1 0 0000 0000 0 1 0   // Producer in MEM
1 0300 5 1 0 0000 0000 0 1 0   // Producer in WB
1 0300 5 1 0 0000 0000 0 0 0   // Producer gone, r5 pushed once
1 01a0 0 0 0 0000 0000 0 1 2   // rt reads r5 in ID
1 01a0 0 0 0 0000 0000 0 1 1   // r5 in EX, no stray copies behind it
1 01a0 0 0 0 0000 0000 0 1 0
0 0000 0 0 0 0000 0000 0 0 0   // Idle while r5 sits in WB
1 2800 2 1 0 0000 0000 0 0 0   // JAL with rd 2 writes r7
1 0220 0 0 0 0000 0000 0 0 0   // Reader of r2 sees nothing
1 01e0 0 0 0 0000 0000 0 1 1   // rt reads r7 in EX
1 0720 0 0 0 0000 0000 0 1 0   // rs reads r7 in MEM
0 0000 0 0 0 0000 0000 0 0 0
1 2000 0 0 0 0000 0000 0 0 0   // Plain jump
1 0140 0 0 0 0000 0000 0 1 0   // Jump bubble only
1 0140 0 0 0 0000 0000 0 0 0
1 1140 0 0 1 0100 0020 0 0 0   // Store to 0120
1 1140 0 0 1 0110 0010 0 1 0   // Same sum from other operands
1 1140 0 0 1 0110 0014 0 0 0   // Store to 0124
1 1140 0 0 1 0200 ff20 0 1 0   // Sum wraps to 0120, older store in MEM
1 0140 4 1 0 0000 0000 0 0 0   // Producer of r4
1 0480 0 0 0 0000 0000 1 0 0   // Taken branch kills r4 in ID
1 0400 0 0 0 0000 0000 0 0 0   // Not in EX
1 0400 0 0 0 0000 0000 0 0 0   // Not in MEM
1 0400 0 0 0 0000 0000 0 0 0   // Not in WB
1 0140 6 1 0 0000 0000 0 0 0   // Producer of r6
1 0140 0 0 0 0000 0000 0 0 0
1 0600 0 0 0 0000 0000 1 1 0   // r6 in EX still stalls, forward masked by the branch
